// File: flist.f
+incdir+include
logic/flash_boot_pkg.sv
logic/spi_clock_gen.sv
logic/flash_sequencer.sv
logic/flash_byte_reader.sv
logic/word_packer.sv
logic/flash_boot_top.sv
sim/flash_boot_checker.sv
sim/flash_boot_tb.sv

// File: include/flash_boot_defs.svh
`ifndef FLASH_BOOT_DEFS_SVH
`define FLASH_BOOT_DEFS_SVH

//////////////////////////////
// SPI flash command bytes
//////////////////////////////

// Reset enable, must directly precede the reset command
`define FLASH_CMD_RESET_ENABLE 8'h66
// Software reset
`define FLASH_CMD_RESET 8'h99
// Plain single-bit read, no dummy cycles
`define FLASH_CMD_READ 8'h03

//////////////////////////////
// Boot image location
//////////////////////////////

// Byte offset of the boot image inside the flash
`define FLASH_READ_OFFSET 24'h100000
// First memory word written by the loader
`define LOAD_BASE 15'd0

//////////////////////////////
// Timing
//////////////////////////////

// CLK cycles per SCK level, so one SCK period is twice this
`define FLASH_HALF_PERIOD 8
// Idle CLK cycles with SSB high after the reset frames
`define FLASH_RESET_WAIT 400

`endif

// File: logic/flash_boot_pkg.sv
`default_nettype none

package flash_boot_pkg;

  //////////////////////////////
  // Data widths
  //////////////////////////////

  // One byte as shifted out of the flash
  typedef logic [7:0] byte_t;

  // One memory word, two flash bytes big-endian
  typedef logic [15:0] word_t;

  // Word address into the 32K word memory
  typedef logic [14:0] mem_addr_t;

  // Byte offset sent with the read command
  typedef logic [23:0] flash_addr_t;

  //////////////////////////////
  // Boot sequencer states
  //////////////////////////////

  // Frame select and release cycles live inside the frame states
  typedef enum logic [2:0] {
    RESET_ENABLE,
    RESET_EXEC,
    RESET_WAIT,
    SEND_READ,
    READ_DATA,
    DONE
  } seq_state_t;

endpackage

`default_nettype wire

// File: logic/flash_boot_top.sv
`timescale 1ns/1ps
`default_nettype none

module flash_boot_top #(
  parameter int boot_words = 32768
) (
  input  wire                       CLK,
  input  wire                       rst_n,
  // SPI flash pins
  input  wire                       FLASH_IO1,
  output logic                      FLASH_SCK,
  output logic                      FLASH_SSB,
  output logic                      FLASH_IO0,
  output logic                      FLASH_IO2,
  output logic                      FLASH_IO3,
  // Memory write port
  output logic                      mem_we,
  output flash_boot_pkg::mem_addr_t mem_addr,
  output flash_boot_pkg::word_t     mem_data,
  // Load finished
  output logic                      boot_done
);

  import flash_boot_pkg::*;

  // SCK control and edge strobes
  logic  sck_enable;
  logic  sck_rise;
  logic  sck_fall;

  // Data phase path
  logic  read_enable;
  logic  byte_valid;
  byte_t byte_data;
  logic  load_done;

  // WP# and HOLD# unused, held inactive
  assign FLASH_IO2 = 1'b1;
  assign FLASH_IO3 = 1'b1;

  //////////////////////////////
  // SCK generation
  //////////////////////////////
  spi_clock_gen u_spi_clock_gen (
    .CLK        (CLK),
    .rst_n      (rst_n),
    .sck_enable (sck_enable),
    .FLASH_SCK  (FLASH_SCK),
    .sck_rise   (sck_rise),
    .sck_fall   (sck_fall)
  );

  //////////////////////////////
  // Command framing
  //////////////////////////////
  flash_sequencer u_flash_sequencer (
    .CLK         (CLK),
    .rst_n       (rst_n),
    .sck_rise    (sck_rise),
    .sck_fall    (sck_fall),
    .load_done   (load_done),
    .FLASH_SSB   (FLASH_SSB),
    .FLASH_IO0   (FLASH_IO0),
    .sck_enable  (sck_enable),
    .read_enable (read_enable),
    .boot_done   (boot_done)
  );

  //////////////////////////////
  // Data phase
  //////////////////////////////
  flash_byte_reader u_flash_byte_reader (
    .CLK         (CLK),
    .rst_n       (rst_n),
    .read_enable (read_enable),
    .sck_fall    (sck_fall),
    .FLASH_IO1   (FLASH_IO1),
    .byte_valid  (byte_valid),
    .byte_data   (byte_data)
  );

  word_packer #(
    .boot_words (boot_words)
  ) u_word_packer (
    .CLK        (CLK),
    .rst_n      (rst_n),
    .byte_valid (byte_valid),
    .byte_data  (byte_data),
    .mem_we     (mem_we),
    .mem_addr   (mem_addr),
    .mem_data   (mem_data),
    .load_done  (load_done)
  );

endmodule

`default_nettype wire

// File: logic/flash_byte_reader.sv
`timescale 1ns/1ps
`default_nettype none

module flash_byte_reader (
  input  wire                   CLK,
  input  wire                   rst_n,
  input  wire                   read_enable,
  input  wire                   sck_fall,
  input  wire                   FLASH_IO1,
  output logic                  byte_valid,
  output flash_boot_pkg::byte_t byte_data
);

  import flash_boot_pkg::*;

  // Bits collected so far in MSB first order
  byte_t      shift_in;
  logic [2:0] bit_cnt;

  //////////////////////////////
  // Serial to byte
  //////////////////////////////
  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      bit_cnt    <= '0;
      byte_valid <= 1'b0;
    end else begin
      byte_valid <= 1'b0;
      if (!read_enable) begin
        // Outside the data phase every byte restarts at bit 7
        bit_cnt <= '0;
      end else if (sck_fall) begin
        bit_cnt <= bit_cnt + 1'b1;
        // Eighth bit completes the byte
        if (bit_cnt == 3'd7) begin
          byte_valid <= 1'b1;
        end
      end
    end
  end

  // Shift register and finished byte
  always_ff @(posedge CLK) begin
    if (read_enable && sck_fall) begin
      shift_in <= {shift_in[6:0], FLASH_IO1};
      // Hand the finished byte over while the next one builds up
      if (bit_cnt == 3'd7) begin
        byte_data <= {shift_in[6:0], FLASH_IO1};
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/flash_sequencer.sv
`timescale 1ns/1ps
`default_nettype none
`include "flash_boot_defs.svh"

module flash_sequencer (
  input  wire  CLK,
  input  wire  rst_n,
  input  wire  sck_rise,
  input  wire  sck_fall,
  input  wire  load_done,
  output logic FLASH_SSB,
  output logic FLASH_IO0,
  output logic sck_enable,
  output logic read_enable,
  output logic boot_done
);

  import flash_boot_pkg::*;

  localparam flash_addr_t READ_OFFSET = `FLASH_READ_OFFSET;

  // Gap counter sized for the post-reset wait
  localparam int WAIT_W = $clog2(`FLASH_RESET_WAIT);
  // Frame start in SEND_READ adds one more SSB high cycle
  localparam logic [WAIT_W-1:0] WAIT_LAST = WAIT_W'(`FLASH_RESET_WAIT - 2);

  seq_state_t        state;
  logic [31:0]       frame_word;
  logic [31:0]       shift_out;
  logic [5:0]        rise_cnt;
  logic [WAIT_W-1:0] wait_cnt;

  //////////////////////////////
  // Frame contents
  //////////////////////////////

  // Commands left aligned so bit 31 always goes first
  always_comb begin
    case (state)
      RESET_ENABLE: frame_word = {`FLASH_CMD_RESET_ENABLE, 24'h000000};
      RESET_EXEC:   frame_word = {`FLASH_CMD_RESET, 24'h000000};
      default:      frame_word = {`FLASH_CMD_READ, READ_OFFSET};
    endcase
  end

  //////////////////////////////
  // Sequencer FSM
  //////////////////////////////
  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      state       <= RESET_ENABLE;
      FLASH_SSB   <= 1'b1;
      FLASH_IO0   <= 1'b0;
      sck_enable  <= 1'b0;
      read_enable <= 1'b0;
      boot_done   <= 1'b0;
      rise_cnt    <= '0;
      wait_cnt    <= '0;
    end else begin
      case (state)
        RESET_ENABLE, RESET_EXEC, SEND_READ: begin
          if (!sck_enable) begin
            if (FLASH_SSB) begin
              // Select the flash and preload the MSB
              FLASH_SSB <= 1'b0;
              FLASH_IO0 <= frame_word[31];
              shift_out <= {frame_word[30:0], 1'b0};
            end else if (rise_cnt == 6'd0) begin
              // Clock starts one cycle after select
              sck_enable <= 1'b1;
            end else begin
              // Release one cycle after the clock stopped
              FLASH_SSB <= 1'b1;
              FLASH_IO0 <= 1'b0;
              rise_cnt  <= '0;
              if (state == RESET_ENABLE) begin
                state <= RESET_EXEC;
              end else begin
                wait_cnt <= '0;
                state    <= RESET_WAIT;
              end
            end
          end else begin
            // Flash latches IO0 on the rise
            if (sck_rise) begin
              rise_cnt <= rise_cnt + 1'b1;
              // Reset commands stop after their eighth bit
              if (state != SEND_READ && rise_cnt == 6'd7) begin
                sck_enable <= 1'b0;
              end
            end
            // Next bit goes out on the fall
            if (sck_fall) begin
              FLASH_IO0 <= shift_out[31];
              shift_out <= {shift_out[30:0], 1'b0};
              // Command and address done, clock keeps running for data
              if (state == SEND_READ && rise_cnt == 6'd32) begin
                read_enable <= 1'b1;
                state       <= READ_DATA;
              end
            end
          end
        end

        RESET_WAIT: begin
          // Let the flash finish its internal reset
          if (wait_cnt == WAIT_LAST) begin
            wait_cnt <= '0;
            state    <= SEND_READ;
          end else begin
            wait_cnt <= wait_cnt + 1'b1;
          end
        end

        READ_DATA: begin
          // Last word written, stop the clock
          if (load_done) begin
            sck_enable  <= 1'b0;
            read_enable <= 1'b0;
            state       <= DONE;
          end
        end

        default: begin
          // Deselect and hold here
          FLASH_SSB <= 1'b1;
          boot_done <= 1'b1;
        end
      endcase
    end
  end

  // SCK only runs inside a selected frame
  assert property (@(posedge CLK) disable iff (!rst_n)
    sck_enable |-> !FLASH_SSB);

  // Boot completion is sticky until reset
  assert property (@(posedge CLK) disable iff (!rst_n)
    boot_done |=> boot_done);

endmodule

`default_nettype wire

// File: logic/spi_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none
`include "flash_boot_defs.svh"

module spi_clock_gen (
  input  wire  CLK,
  input  wire  rst_n,
  input  wire  sck_enable,
  output logic FLASH_SCK,
  output logic sck_rise,
  output logic sck_fall
);

  // Divider wide enough to hold one SCK level
  localparam int DIV_W = $clog2(`FLASH_HALF_PERIOD + 1);
  localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`FLASH_HALF_PERIOD - 1);

  logic [DIV_W-1:0] div_cnt;
  logic             toggle;

  // Last CLK cycle of the current SCK level
  assign toggle = sck_enable && (div_cnt == DIV_LAST);

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      FLASH_SCK <= 1'b0;
      sck_rise  <= 1'b0;
      sck_fall  <= 1'b0;
      div_cnt   <= '0;
    end else begin
      // Strobes last a single cycle
      sck_rise <= 1'b0;
      sck_fall <= 1'b0;
      if (!sck_enable) begin
        // Idle clock parks low and restarts a full level when enabled
        FLASH_SCK <= 1'b0;
        div_cnt   <= '0;
      end else if (toggle) begin
        div_cnt   <= '0;
        FLASH_SCK <= ~FLASH_SCK;
        // Flag the edge that SCK is about to take
        if (!FLASH_SCK) begin
          sck_rise <= 1'b1;
        end else begin
          sck_fall <= 1'b1;
        end
      end else begin
        div_cnt <= div_cnt + 1'b1;
      end
    end
  end

  // One SCK edge per strobe cycle
  assert property (@(posedge CLK) disable iff (!rst_n)
    !(sck_rise && sck_fall));

endmodule

`default_nettype wire

// File: logic/word_packer.sv
`timescale 1ns/1ps
`default_nettype none
`include "flash_boot_defs.svh"

module word_packer #(
  parameter int boot_words = 32768
) (
  input  wire                       CLK,
  input  wire                       rst_n,
  input  wire                       byte_valid,
  input  wire flash_boot_pkg::byte_t byte_data,
  output logic                      mem_we,
  output flash_boot_pkg::mem_addr_t mem_addr,
  output flash_boot_pkg::word_t     mem_data,
  output logic                      load_done
);

  import flash_boot_pkg::*;

  // Index of the final word in the image
  localparam mem_addr_t LAST_WORD = mem_addr_t'(boot_words - 1);

  byte_t     high_byte;
  logic      have_high;
  mem_addr_t word_idx;
  logic      take;

  // Bytes past the end of the image are dropped
  assign take = byte_valid && !load_done;

  //////////////////////////////
  // Pairing and write strobe
  //////////////////////////////
  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      have_high <= 1'b0;
      mem_we    <= 1'b0;
      word_idx  <= '0;
      load_done <= 1'b0;
    end else begin
      mem_we <= 1'b0;
      if (take) begin
        have_high <= ~have_high;
        // Second byte of a pair completes the word
        if (have_high) begin
          mem_we   <= 1'b1;
          word_idx <= word_idx + 1'b1;
          if (word_idx == LAST_WORD) begin
            load_done <= 1'b1;
          end
        end
      end
    end
  end

  // Big-endian word, first byte on top
  always_ff @(posedge CLK) begin
    if (take) begin
      if (!have_high) begin
        high_byte <= byte_data;
      end else begin
        mem_data <= {high_byte, byte_data};
        mem_addr <= `LOAD_BASE + word_idx;
      end
    end
  end

  // Each write lasts exactly one cycle
  assert property (@(posedge CLK) disable iff (!rst_n)
    mem_we |=> !mem_we);

  // Memory stays untouched once the load is complete
  assert property (@(posedge CLK) disable iff (!rst_n)
    load_done |=> !mem_we);

endmodule

`default_nettype wire

// File: sim/flash_boot_checker.sv
`timescale 1ns/1ps
`default_nettype none
`include "flash_boot_defs.svh"

module flash_boot_checker #(
  parameter int boot_words = 48
) (
  input  wire                            CLK,
  input  wire                            rst_n,
  input  wire                            FLASH_SCK,
  input  wire                            FLASH_SSB,
  input  wire                            FLASH_IO0,
  input  wire                            FLASH_IO2,
  input  wire                            FLASH_IO3,
  input  wire                            mem_we,
  input  wire flash_boot_pkg::mem_addr_t mem_addr,
  input  wire flash_boot_pkg::word_t     mem_data,
  input  wire                            boot_done,
  output logic                           done,
  output int                             errors
);

  import flash_boot_pkg::*;

  // Cycle limits for each wait
  localparam int RESET_LIMIT  = 100;
  localparam int FRAME_LIMIT  = 1000;
  localparam int GAP_LIMIT    = `FLASH_RESET_WAIT + 100;
  localparam int WRITE_LIMIT  = 1000;
  localparam int DONE_LIMIT   = 100;
  localparam int QUIET_CYCLES = 200;
  localparam int NUM_TESTS    = 5;

  bit aborted;
  int tests_run;
  int tests_failed;

  //////////////////////////////
  // Reporting
  //////////////////////////////
  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  // Later tests are skipped once a wait has run out
  task automatic report_timeout(input string what);
    seq_state_t st;
    st = flash_boot_tb.i_dut.u_flash_sequencer.state;
    errors++;
    aborted = 1'b1;
    $display("Timed out waiting for %s, sequencer in state %s", what, st.name());
  endtask

  task automatic end_test(input string name, input int err_start);
    tests_run++;
    if (errors == err_start) begin
      $display("Test %0d %s: PASS", tests_run, name);
    end else begin
      tests_failed++;
      $display("Test %0d %s: FAIL, %0d errors", tests_run, name, errors - err_start);
    end
  endtask

  //////////////////////////////
  // SPI frame decoding
  //////////////////////////////
  task automatic wait_ssb(input logic level, input string what);
    int n;
    n = 0;
    while (FLASH_SSB !== level && n < FRAME_LIMIT) begin
      @(negedge CLK);
      n++;
    end
    if (FLASH_SSB !== level) report_timeout(what);
  endtask

  // IO0 captured on each SCK rise until deselect or max_rises
  task automatic capture_bits(input int max_rises, input string what,
                              output int rises, output logic [31:0] bits);
    int   n;
    logic prev_sck;
    n        = 0;
    rises    = 0;
    bits     = '0;
    prev_sck = FLASH_SCK;
    while (FLASH_SSB === 1'b0 && rises < max_rises && n < FRAME_LIMIT) begin
      @(negedge CLK);
      n++;
      if (FLASH_SCK === 1'b1 && prev_sck === 1'b0) begin
        bits = {bits[30:0], FLASH_IO0};
        rises++;
      end
      prev_sck = FLASH_SCK;
    end
    if (FLASH_SSB === 1'b0 && rises < max_rises) report_timeout(what);
  endtask

  task automatic check_command_frame(input logic [7:0] cmd, input string what);
    int          rises;
    logic [31:0] bits;
    wait_ssb(1'b0, {what, " select"});
    if (!aborted) begin
      capture_bits(64, {what, " deselect"}, rises, bits);
    end
    if (!aborted) begin
      check_value({what, " SCK rises"}, rises, 8);
      check_value({what, " FLASH_IO0 byte"}, bits[7:0], cmd);
    end
  endtask

  task automatic wait_write(input string what);
    int n;
    n = 0;
    do begin
      @(negedge CLK);
      n++;
    end while (mem_we !== 1'b1 && n < WRITE_LIMIT);
    if (mem_we !== 1'b1) report_timeout(what);
  endtask

  //////////////////////////////
  // Test sequence
  //////////////////////////////
  initial begin : run_tests
    int          err_start;
    int          n;
    int          rises;
    int          gap;
    int          writes;
    int          sck_edges;
    int          late_writes;
    int          done_drops;
    logic [31:0] bits;
    logic        ref_sck;
    logic [15:0] exp_data;
    done         = 1'b0;
    errors       = 0;
    aborted      = 1'b0;
    tests_run    = 0;
    tests_failed = 0;

    // Outputs still hold reset values on the first sample after release
    err_start = errors;
    n = 0;
    while (rst_n !== 1'b1 && n < RESET_LIMIT) begin
      @(negedge CLK);
      n++;
    end
    if (rst_n !== 1'b1) begin
      report_timeout("reset release");
    end else begin
      check_value("FLASH_SSB", FLASH_SSB, 1);
      check_value("FLASH_SCK", FLASH_SCK, 0);
      check_value("FLASH_IO0", FLASH_IO0, 0);
      check_value("FLASH_IO2", FLASH_IO2, 1);
      check_value("FLASH_IO3", FLASH_IO3, 1);
      check_value("mem_we", mem_we, 0);
      check_value("boot_done", boot_done, 0);
    end
    end_test("reset values", err_start);

    // Two reset frames and the idle gap after them
    if (!aborted) begin
      err_start = errors;
      check_command_frame(`FLASH_CMD_RESET_ENABLE, "reset enable frame");
      if (!aborted) begin
        check_command_frame(`FLASH_CMD_RESET, "reset frame");
      end
      if (!aborted) begin
        gap = 0;
        while (FLASH_SSB === 1'b1 && gap < GAP_LIMIT) begin
          @(negedge CLK);
          gap++;
        end
        if (FLASH_SSB === 1'b1) begin
          report_timeout("read frame select");
        end else if (gap < `FLASH_RESET_WAIT) begin
          errors++;
          $display("CHECK FAILED FLASH_SSB high gap: got 0x%0h, expected at least 0x%0h",
                   gap, `FLASH_RESET_WAIT);
        end
      end
      end_test("reset frames", err_start);
    end

    // Read command and start offset
    if (!aborted) begin
      err_start = errors;
      capture_bits(32, "read header", rises, bits);
      if (!aborted) begin
        check_value("read header SCK rises", rises, 32);
        check_value("read header FLASH_IO0 bits", bits, {`FLASH_CMD_READ, `FLASH_READ_OFFSET});
      end
      end_test("read header", err_start);
    end

    // Words against big-endian pairs of image bytes
    if (!aborted) begin
      err_start = errors;
      writes = 0;
      while (writes < boot_words && !aborted) begin
        wait_write($sformatf("memory write %0d", writes));
        if (!aborted) begin
          exp_data = {flash_boot_tb.flash_image[2 * writes],
                      flash_boot_tb.flash_image[2 * writes + 1]};
          check_value($sformatf("mem_addr of write %0d", writes), mem_addr,
                      `LOAD_BASE + writes);
          check_value($sformatf("mem_data of write %0d", writes), mem_data, exp_data);
          // Done flag stays low while words are still arriving
          check_value($sformatf("boot_done at write %0d", writes), boot_done, 0);
          writes++;
        end
      end
      end_test("data writes", err_start);
    end

    // Release after the last word and a quiet bus after it
    if (!aborted) begin
      err_start   = errors;
      late_writes = 0;
      n = 0;
      while (boot_done !== 1'b1 && n < DONE_LIMIT) begin
        @(negedge CLK);
        n++;
        if (mem_we === 1'b1) late_writes++;
      end
      if (boot_done !== 1'b1) begin
        report_timeout("boot_done");
      end else begin
        check_value("FLASH_SSB at boot_done", FLASH_SSB, 1);
        ref_sck    = FLASH_SCK;
        sck_edges  = 0;
        done_drops = 0;
        repeat (QUIET_CYCLES) begin
          @(negedge CLK);
          if (FLASH_SCK !== ref_sck) sck_edges++;
          ref_sck = FLASH_SCK;
          if (mem_we === 1'b1) late_writes++;
          if (boot_done !== 1'b1) done_drops++;
        end
        check_value("FLASH_SCK edges after boot_done", sck_edges, 0);
        check_value("mem_we pulses after the last word", late_writes, 0);
        check_value("boot_done low cycles after rising", done_drops, 0);
      end
      end_test("end of load", err_start);
    end

    $display("Tests run %0d, passed %0d, failed %0d, skipped %0d, errors %0d",
             tests_run, tests_run - tests_failed, tests_failed,
             NUM_TESTS - tests_run, errors);
    done = 1'b1;
  end

endmodule

`default_nettype wire

// File: sim/flash_boot_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "flash_boot_defs.svh"

module flash_boot_tb;

  import flash_boot_pkg::*;

  localparam int BOOT_WORDS  = 48;
  localparam int IMAGE_BYTES = 2 * BOOT_WORDS;
  // Whole boot takes roughly 13k cycles at 48 words
  localparam int RUN_TIMEOUT = 40000;

  logic      CLK;
  logic      rst_n;
  logic      FLASH_IO1;
  logic      FLASH_SCK;
  logic      FLASH_SSB;
  logic      FLASH_IO0;
  logic      FLASH_IO2;
  logic      FLASH_IO3;
  logic      mem_we;
  mem_addr_t mem_addr;
  word_t     mem_data;
  logic      boot_done;
  logic      check_done;
  int        check_errors;

  // Flash contents from FLASH_READ_OFFSET onward
  byte_t flash_image [0:IMAGE_BYTES-1];

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    lfsr_step = {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
  endfunction

  //////////////////////////////
  // Clock, image and reset
  //////////////////////////////
  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  initial begin : stimulus
    logic [31:0] lfsr;
    byte_t       value;
    int          i;
    int          b;
    rst_n = 1'b0;
    lfsr  = 32'd82294;
    value = '0;
    // One LFSR step per image bit
    for (i = 0; i < IMAGE_BYTES; i++) begin
      for (b = 0; b < 8; b++) begin
        lfsr  = lfsr_step(lfsr);
        value = {value[6:0], lfsr[0]};
      end
      flash_image[i] = value;
    end
    repeat (3) @(posedge CLK);
    #1;
    rst_n = 1'b1;
  end

  //////////////////////////////
  // SPI flash model
  //////////////////////////////
  initial begin : flash_model
    logic        prev_sck;
    logic [31:0] rx_bits;
    int          rise_cnt;
    int          start_idx;
    int          bit_pos;
    FLASH_IO1 = 1'b0;
    prev_sck  = 1'b0;
    rx_bits   = '0;
    rise_cnt  = 0;
    start_idx = 0;
    forever begin
      @(posedge CLK);
      #1;
      if (FLASH_SSB !== 1'b0) begin
        // Deselected, next frame begins at its first bit
        rise_cnt  = 0;
        FLASH_IO1 = 1'b0;
      end else if (FLASH_SCK === 1'b1 && prev_sck === 1'b0) begin
        if (rise_cnt < 32) begin
          // Command then address, IO0 sampled on the rise
          rx_bits = {rx_bits[30:0], FLASH_IO0};
          if (rise_cnt == 31) begin
            start_idx = int'(rx_bits[23:0]) - int'(`FLASH_READ_OFFSET);
          end
        end else if (rx_bits[31:24] == `FLASH_CMD_READ) begin
          // Data out MSB first, zeros past the image
          bit_pos = (rise_cnt - 32) + 8 * start_idx;
          if (bit_pos >= 0 && bit_pos < 8 * IMAGE_BYTES) begin
            FLASH_IO1 = flash_image[bit_pos / 8][7 - (bit_pos % 8)];
          end else begin
            FLASH_IO1 = 1'b0;
          end
        end
        rise_cnt++;
      end
      prev_sck = FLASH_SCK;
    end
  end

  //////////////////////////////
  // DUT and checker
  //////////////////////////////
  flash_boot_top #(
    .boot_words (BOOT_WORDS)
  ) i_dut (
    .CLK       (CLK),
    .rst_n     (rst_n),
    .FLASH_IO1 (FLASH_IO1),
    .FLASH_SCK (FLASH_SCK),
    .FLASH_SSB (FLASH_SSB),
    .FLASH_IO0 (FLASH_IO0),
    .FLASH_IO2 (FLASH_IO2),
    .FLASH_IO3 (FLASH_IO3),
    .mem_we    (mem_we),
    .mem_addr  (mem_addr),
    .mem_data  (mem_data),
    .boot_done (boot_done)
  );

  flash_boot_checker #(
    .boot_words (BOOT_WORDS)
  ) i_checker (
    .CLK       (CLK),
    .rst_n     (rst_n),
    .FLASH_SCK (FLASH_SCK),
    .FLASH_SSB (FLASH_SSB),
    .FLASH_IO0 (FLASH_IO0),
    .FLASH_IO2 (FLASH_IO2),
    .FLASH_IO3 (FLASH_IO3),
    .mem_we    (mem_we),
    .mem_addr  (mem_addr),
    .mem_data  (mem_data),
    .boot_done (boot_done),
    .done      (check_done),
    .errors    (check_errors)
  );

  // Overall limit on the run
  initial begin : run_control
    int cycles;
    cycles = 0;
    while (check_done !== 1'b1 && cycles < RUN_TIMEOUT) begin
      @(posedge CLK);
      cycles++;
    end
    if (check_done === 1'b1 && check_errors == 0) begin
      $display("Finished with no errors");
    end else begin
      if (check_done !== 1'b1) begin
        $display("Checker did not complete within %0d cycles", RUN_TIMEOUT);
      end
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire
